// ==== files.f ====
+incdir+source
source/isa_pkg.sv
source/core_pkg.sv
source/inst_decoder.sv
source/alu.sv
source/regfile.sv
source/cpu_fsm.sv
source/mycpu_top.sv
verification/tb_memory.sv
verification/tb_mycpu.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mycpu -f files.f -o tb_mycpu \
    && ./obj_dir/tb_mycpu | grep -F "No errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== source/alu.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"
`default_nettype none

module alu (
    input  isa_pkg::alu_op_e     op,
    input  logic [`CPU_XLEN-1:0] src1,
    input  logic [`CPU_XLEN-1:0] src2,
    output logic [`CPU_XLEN-1:0] result
);
    import isa_pkg::*;

    logic       lt_signed;
    logic       lt_unsigned;
    logic [4:0] shamt;

    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;
    // only the low five bits of the second source count for shifts.
    assign shamt       = src2[4:0];

    always_comb begin
        case (op)
            alu_add:  result = src1 + src2;
            alu_sub:  result = src1 - src2;
            alu_slt:  result = {{(`CPU_XLEN-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(`CPU_XLEN-1){1'b0}}, lt_unsigned};
            alu_and:  result = src1 & src2;
            alu_nor:  result = ~(src1 | src2);
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_sll:  result = src1 << shamt;
            alu_srl:  result = src1 >> shamt;
            alu_sra:  result = $signed(src1) >>> shamt;
            // the decoder already placed the upper immediate in src2.
            alu_lui:  result = src2;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/core_pkg.sv ====
`include "cpu_consts.svh"
`default_nettype none

package core_pkg;

    import isa_pkg::*;

    typedef enum logic [2:0] {
        st_fetch     = 3'd0,
        st_decode    = 3'd1,
        st_execute   = 3'd2,
        st_memory    = 3'd3,
        st_writeback = 3'd4
    } cpu_state_e;

    // everything the datapath and the sequencer need to know about one instruction.
    typedef struct packed {
        inst_kind_e           kind;
        alu_op_e              alu_op;
        logic [4:0]           rj;
        logic [4:0]           rk_or_rd;
        logic [4:0]           dest;
        logic                 src1_is_pc;
        logic                 src2_is_imm;
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
        logic                 is_branch;
        logic [`CPU_XLEN-1:0] imm;
        logic [`CPU_XLEN-1:0] br_offs;
    } decode_t;

    typedef struct packed {
        logic                 we;
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] wdata;
    } sram_req_t;

    typedef struct packed {
        logic                 we;
        logic [`CPU_XLEN-1:0] pc;
        logic [4:0]           wnum;
        logic [`CPU_XLEN-1:0] wdata;
    } wb_trace_t;

endpackage

`default_nettype wire

// ==== source/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`default_nettype none

// width of a machine word, of the datapath and of every address.
`define CPU_XLEN 32

// number of general registers; r0 always reads as zero.
`define CPU_REG_COUNT 32

// address of the first instruction fetched after reset.
`define CPU_RESET_PC 32'h1c00_0000

`default_nettype wire

`endif

// ==== source/cpu_fsm.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"
`default_nettype none

module cpu_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  core_pkg::decode_t      dec,
    input  logic                   br_taken,
    input  logic [`CPU_XLEN-1:0]   br_target,
    input  logic [`CPU_XLEN-1:0]   inst_rdata,
    output core_pkg::cpu_state_e   state,
    output logic [`CPU_XLEN-1:0]   pc,
    output logic [`CPU_XLEN-1:0]   instr
);
    import isa_pkg::*;
    import core_pkg::*;

    cpu_state_e           next_state;
    logic [`CPU_XLEN-1:0] next_pc;

    always_comb begin
        case (state)
            st_fetch: next_state = st_decode;
            // plain branches are finished once the pc has been resolved.
            st_decode: begin
                if (dec.kind inside {kind_b, kind_beq, kind_bne}) begin
                    next_state = st_fetch;
                end else begin
                    next_state = st_execute;
                end
            end
            st_execute: begin
                if (dec.mem_read || dec.mem_write) begin
                    next_state = st_memory;
                end else begin
                    next_state = st_writeback;
                end
            end
            st_memory:    next_state = dec.mem_read ? st_writeback : st_fetch;
            st_writeback: next_state = st_fetch;
            default:      next_state = st_fetch;
        endcase
    end

    assign next_pc = br_taken ? br_target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
            pc    <= `CPU_RESET_PC;
            instr <= '0;
        end else begin
            state <= next_state;
            if (state == st_fetch) begin
                instr <= inst_rdata;
            end
            if (state == st_decode) begin
                pc <= next_pc;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/inst_decoder.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"
`default_nettype none

module inst_decoder (
    input  logic [`CPU_XLEN-1:0] instr,
    output core_pkg::decode_t    dec
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    inst_kind_e  kind;

    assign op_31_26 = instr[31:26];
    assign op_25_22 = instr[25:22];
    assign op_21_20 = instr[21:20];
    assign op_19_15 = instr[19:15];

    assign rd  = instr[4:0];
    assign rj  = instr[9:5];
    assign rk  = instr[14:10];
    assign i12 = instr[21:10];
    assign i20 = instr[24:5];
    assign i16 = instr[25:10];
    // the 26-bit offset is split, with its upper ten bits in the low field.
    assign i26 = {instr[9:0], instr[25:10]};

    always_comb begin
        kind = kind_illegal;
        case (op_31_26)
            6'h00: begin
                if (op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
                    case (op_19_15)
                        5'h00:   kind = kind_add_w;
                        5'h02:   kind = kind_sub_w;
                        5'h04:   kind = kind_slt;
                        5'h05:   kind = kind_sltu;
                        5'h08:   kind = kind_nor;
                        5'h09:   kind = kind_and;
                        5'h0a:   kind = kind_or;
                        5'h0b:   kind = kind_xor;
                        default: kind = kind_illegal;
                    endcase
                end else if (op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
                    case (op_19_15)
                        5'h01:   kind = kind_slli_w;
                        5'h09:   kind = kind_srli_w;
                        5'h11:   kind = kind_srai_w;
                        default: kind = kind_illegal;
                    endcase
                end else if (op_25_22 == 4'ha) begin
                    kind = kind_addi_w;
                end
            end
            6'h05: begin
                if (!instr[25]) begin
                    kind = kind_lu12i_w;
                end
            end
            6'h0a: begin
                if (op_25_22 == 4'h2) begin
                    kind = kind_ld_w;
                end else if (op_25_22 == 4'h6) begin
                    kind = kind_st_w;
                end
            end
            6'h13:   kind = kind_jirl;
            6'h14:   kind = kind_b;
            6'h15:   kind = kind_bl;
            6'h16:   kind = kind_beq;
            6'h17:   kind = kind_bne;
            default: kind = kind_illegal;
        endcase
    end

    always_comb begin
        dec.kind = kind;
        dec.rj   = rj;
        // branches and stores read their second operand from the rd field.
        dec.rk_or_rd = (kind inside {kind_beq, kind_bne, kind_st_w}) ? rd : rk;
        dec.dest     = (kind == kind_bl) ? 5'd1 : rd;

        case (kind)
            kind_sub_w:   dec.alu_op = alu_sub;
            kind_slt:     dec.alu_op = alu_slt;
            kind_sltu:    dec.alu_op = alu_sltu;
            kind_nor:     dec.alu_op = alu_nor;
            kind_and:     dec.alu_op = alu_and;
            kind_or:      dec.alu_op = alu_or;
            kind_xor:     dec.alu_op = alu_xor;
            kind_slli_w:  dec.alu_op = alu_sll;
            kind_srli_w:  dec.alu_op = alu_srl;
            kind_srai_w:  dec.alu_op = alu_sra;
            kind_lu12i_w: dec.alu_op = alu_lui;
            default:      dec.alu_op = alu_add;
        endcase

        dec.src1_is_pc  = kind inside {kind_jirl, kind_bl};
        dec.src2_is_imm = kind inside {kind_slli_w, kind_srli_w, kind_srai_w, kind_addi_w,
                                       kind_ld_w, kind_st_w, kind_lu12i_w, kind_jirl, kind_bl};
        dec.reg_write   = !(kind inside {kind_illegal, kind_st_w, kind_b, kind_beq, kind_bne});
        dec.mem_read    = (kind == kind_ld_w);
        dec.mem_write   = (kind == kind_st_w);
        dec.is_branch   = kind inside {kind_b, kind_bl, kind_beq, kind_bne, kind_jirl};

        // the link instructions add 4 to the instruction address.
        if (kind inside {kind_jirl, kind_bl}) begin
            dec.imm = 32'd4;
        end else if (kind == kind_lu12i_w) begin
            dec.imm = {i20, 12'b0};
        end else begin
            dec.imm = {{20{i12[11]}}, i12};
        end

        if (kind inside {kind_b, kind_bl}) begin
            dec.br_offs = {{4{i26[25]}}, i26, 2'b0};
        end else begin
            dec.br_offs = {{14{i16[15]}}, i16, 2'b0};
        end
    end

endmodule

`default_nettype wire

// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // the twenty supported instructions; zero is kept for anything unrecognised.
    typedef enum logic [4:0] {
        kind_illegal = 5'd0,
        kind_add_w   = 5'd1,
        kind_sub_w   = 5'd2,
        kind_slt     = 5'd3,
        kind_sltu    = 5'd4,
        kind_nor     = 5'd5,
        kind_and     = 5'd6,
        kind_or      = 5'd7,
        kind_xor     = 5'd8,
        kind_slli_w  = 5'd9,
        kind_srli_w  = 5'd10,
        kind_srai_w  = 5'd11,
        kind_addi_w  = 5'd12,
        kind_ld_w    = 5'd13,
        kind_st_w    = 5'd14,
        kind_jirl    = 5'd15,
        kind_b       = 5'd16,
        kind_bl      = 5'd17,
        kind_beq     = 5'd18,
        kind_bne     = 5'd19,
        kind_lu12i_w = 5'd20
    } inst_kind_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_nor  = 4'd5,
        alu_or   = 4'd6,
        alu_xor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11
    } alu_op_e;

endpackage

`default_nettype wire

// ==== source/mycpu_top.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"
`default_nettype none

module mycpu_top (
    input  logic                 clk,
    input  logic                 reset,
    output logic [`CPU_XLEN-1:0] inst_addr,
    input  logic [`CPU_XLEN-1:0] inst_rdata,
    output core_pkg::sram_req_t  data_req,
    input  logic [`CPU_XLEN-1:0] data_rdata,
    output core_pkg::wb_trace_t  trace
);
    import isa_pkg::*;
    import core_pkg::*;

    cpu_state_e           state;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] instr;
    decode_t              dec;
    logic [`CPU_XLEN-1:0] rj_value;
    logic [`CPU_XLEN-1:0] rkd_value;
    logic [`CPU_XLEN-1:0] alu_src1;
    logic [`CPU_XLEN-1:0] alu_src2;
    logic [`CPU_XLEN-1:0] alu_result;
    logic                 rj_eq_rd;
    logic                 br_taken;
    logic [`CPU_XLEN-1:0] br_target;
    logic [`CPU_XLEN-1:0] result_q;
    logic [`CPU_XLEN-1:0] load_q;
    logic [`CPU_XLEN-1:0] wb_pc;
    logic [`CPU_XLEN-1:0] wb_value;
    logic                 rf_we;

    cpu_fsm u_fsm (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .br_taken   (br_taken),
        .br_target  (br_target),
        .inst_rdata (inst_rdata),
        .state      (state),
        .pc         (pc),
        .instr      (instr)
    );

    inst_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.rj),
        .rdata1 (rj_value),
        .raddr2 (dec.rk_or_rd),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (dec.dest),
        .wdata  (wb_value)
    );

    alu u_alu (
        .op     (dec.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    assign inst_addr = pc;

    // pc moves on in decode, so link values come from the saved instruction address.
    assign alu_src1 = dec.src1_is_pc ? wb_pc : rj_value;
    assign alu_src2 = dec.src2_is_imm ? dec.imm : rkd_value;

    assign rj_eq_rd = (rj_value == rkd_value);

    always_comb begin
        case (dec.kind)
            kind_beq: br_taken = rj_eq_rd;
            kind_bne: br_taken = !rj_eq_rd;
            default:  br_taken = dec.is_branch;
        endcase
    end

    assign br_target = ((dec.kind == kind_jirl) ? rj_value : pc) + dec.br_offs;

    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            wb_pc <= pc;
        end
        if (state == st_execute) begin
            result_q <= alu_result;
        end
        if (state == st_memory) begin
            load_q <= data_rdata;
        end
    end

    assign wb_value = dec.mem_read ? load_q : result_q;
    assign rf_we    = (state == st_writeback) && dec.reg_write;

    always_comb begin
        data_req.we    = (state == st_memory) && dec.mem_write;
        data_req.addr  = result_q;
        data_req.wdata = rkd_value;
    end

    always_comb begin
        trace.we    = rf_we;
        trace.pc    = wb_pc;
        trace.wnum  = dec.dest;
        trace.wdata = wb_value;
    end

endmodule

`default_nettype wire

// ==== source/regfile.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"
`default_nettype none

module regfile (
    input  logic                 clk,
    input  logic [4:0]           raddr1,
    output logic [`CPU_XLEN-1:0] rdata1,
    input  logic [4:0]           raddr2,
    output logic [`CPU_XLEN-1:0] rdata2,
    input  logic                 we,
    input  logic [4:0]           waddr,
    input  logic [`CPU_XLEN-1:0] wdata
);
    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is never written, so its reads are forced to zero here.
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== verification/tb_memory.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"
`default_nettype none

module tb_memory (
    input  logic                 clk,
    input  logic [`CPU_XLEN-1:0] inst_addr,
    output logic [`CPU_XLEN-1:0] inst_rdata,
    input  core_pkg::sram_req_t  data_req,
    output logic [`CPU_XLEN-1:0] data_rdata
);
    localparam int MEM_WORDS = 1024;

    logic [`CPU_XLEN-1:0] imem [MEM_WORDS];
    logic [`CPU_XLEN-1:0] dmem [MEM_WORDS];
    logic [`CPU_XLEN-1:0] inst_offset;

    // instruction words are counted from the reset address.
    assign inst_offset = inst_addr - `CPU_RESET_PC;
    assign inst_rdata  = imem[inst_offset[11:2]];
    assign data_rdata  = dmem[data_req.addr[11:2]];

    function automatic logic [`CPU_XLEN-1:0] fill_word(input logic [`CPU_XLEN-1:0] addr);
        return addr ^ 32'h5a5a_a5a5 ^ {addr[15:0], addr[31:16]};
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = fill_word(32'(i) << 2);
        end
    end

    always @(posedge clk) begin
        if (data_req.we) begin
            dmem[data_req.addr[11:2]] <= data_req.wdata;
        end
    end

    task automatic write_inst(input logic [`CPU_XLEN-1:0] addr,
                              input logic [`CPU_XLEN-1:0] word);
        logic [`CPU_XLEN-1:0] offset;
        offset = addr - `CPU_RESET_PC;
        imem[offset[11:2]] = word;
    endtask

    function automatic logic [`CPU_XLEN-1:0] read_word(input logic [`CPU_XLEN-1:0] addr);
        return dmem[addr[11:2]];
    endfunction

endmodule

`default_nettype wire

// ==== verification/tb_mycpu.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"
`default_nettype none

module tb_mycpu;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int          CLK_PERIOD = 40;
    localparam int          MEM_WORDS  = 1024;
    localparam int          PROG_MAX   = 64;
    localparam logic [31:0] LCG_SEED   = 32'hfdcf;

    logic                 clk;
    logic                 reset;
    logic [`CPU_XLEN-1:0] inst_addr;
    logic [`CPU_XLEN-1:0] inst_rdata;
    sram_req_t            data_req;
    logic [`CPU_XLEN-1:0] data_rdata;
    wb_trace_t            trace;

    inst_kind_e           prog_kind [PROG_MAX];
    logic [4:0]           prog_rd [PROG_MAX];
    logic [4:0]           prog_rj [PROG_MAX];
    logic [4:0]           prog_rk [PROG_MAX];
    logic [31:0]          prog_imm [PROG_MAX];
    logic [31:0]          prog_word [PROG_MAX];
    int                   prog_len;
    logic [31:0]          model_regs [32];
    logic [31:0]          model_mem [MEM_WORDS];
    wb_trace_t            exp_q [$];
    logic [31:0]          lcg_state;
    int                   errors;
    int                   checks;
    int                   tests_run;
    int                   tests_failed;
    int                   budget_cycles;
    int                   timeout_limit;
    int                   run_cycles;

    mycpu_top UUT (
        .clk        (clk),
        .reset      (reset),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .data_req   (data_req),
        .data_rdata (data_rdata),
        .trace      (trace)
    );

    tb_memory mem (
        .clk        (clk),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .data_req   (data_req),
        .data_rdata (data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // the budget grows with every program the reference model walks through.
    always @(posedge clk) begin
        if (!reset) begin
            run_cycles = run_cycles + 1;
            if (run_cycles > timeout_limit) begin
                $display("timeout: the core stopped producing the expected register writes");
                $display("Errors found");
                $finish;
            end
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] encode(input inst_kind_e k, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk,
                                           input logic [31:0] imm);
        case (k)
            kind_add_w:   return {12'h001, 5'h00, rk, rj, rd};
            kind_sub_w:   return {12'h001, 5'h02, rk, rj, rd};
            kind_slt:     return {12'h001, 5'h04, rk, rj, rd};
            kind_sltu:    return {12'h001, 5'h05, rk, rj, rd};
            kind_nor:     return {12'h001, 5'h08, rk, rj, rd};
            kind_and:     return {12'h001, 5'h09, rk, rj, rd};
            kind_or:      return {12'h001, 5'h0a, rk, rj, rd};
            kind_xor:     return {12'h001, 5'h0b, rk, rj, rd};
            kind_slli_w:  return {12'h004, 5'h01, imm[4:0], rj, rd};
            kind_srli_w:  return {12'h004, 5'h09, imm[4:0], rj, rd};
            kind_srai_w:  return {12'h004, 5'h11, imm[4:0], rj, rd};
            kind_addi_w:  return {10'h00a, imm[11:0], rj, rd};
            kind_lu12i_w: return {7'h0a, imm[19:0], rd};
            kind_ld_w:    return {10'h0a2, imm[11:0], rj, rd};
            kind_st_w:    return {10'h0a6, imm[11:0], rj, rd};
            kind_jirl:    return {6'h13, imm[15:0], rj, rd};
            kind_b:       return {6'h14, imm[15:0], imm[25:16]};
            kind_bl:      return {6'h15, imm[15:0], imm[25:16]};
            kind_beq:     return {6'h16, imm[15:0], rj, rd};
            kind_bne:     return {6'h17, imm[15:0], rj, rd};
            default:      return 32'h0;
        endcase
    endfunction

    // imm holds si12, si20, ui5 or the branch offset in instructions.
    task automatic emit(input inst_kind_e k, input int rd, input int rj, input int rk,
                        input int imm);
        prog_kind[prog_len] = k;
        prog_rd[prog_len]   = rd[4:0];
        prog_rj[prog_len]   = rj[4:0];
        prog_rk[prog_len]   = rk[4:0];
        prog_imm[prog_len]  = imm;
        prog_word[prog_len] = encode(k, rd[4:0], rj[4:0], rk[4:0], imm);
        prog_len = prog_len + 1;
    endtask

    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [31:0] imm;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] val;
        logic [4:0]  dst;
        logic        wr;
        wb_trace_t   ev;
        inst_kind_e  k;
        int          idx;
        int          cycles;
        pc = `CPU_RESET_PC;
        cycles = 0;
        exp_q.delete();
        for (int step = 0; step < 256; step++) begin
            idx = int'((pc - `CPU_RESET_PC) >> 2);
            if (idx < 0 || idx >= prog_len) begin
                $display("model left the program at pc %h", pc);
                errors = errors + 1;
                break;
            end
            k = prog_kind[idx];
            imm = prog_imm[idx];
            if (k == kind_b && imm == 32'h0) begin
                break;
            end
            a = model_regs[prog_rj[idx]];
            b = model_regs[prog_rk[idx]];
            d = model_regs[prog_rd[idx]];
            dst = prog_rd[idx];
            next_pc = pc + 32'd4;
            wr = 1'b1;
            val = 32'h0;
            // addi.w, ld.w and st.w carry a sign-extended 12-bit immediate.
            simm = {{20{imm[11]}}, imm[11:0]};
            addr = a + simm;
            case (k)
                kind_add_w:   val = a + b;
                kind_sub_w:   val = a - b;
                kind_slt:     val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                kind_sltu:    val = (a < b) ? 32'd1 : 32'd0;
                kind_nor:     val = ~(a | b);
                kind_and:     val = a & b;
                kind_or:      val = a | b;
                kind_xor:     val = a ^ b;
                kind_slli_w:  val = a << imm[4:0];
                kind_srli_w:  val = a >> imm[4:0];
                kind_srai_w:  val = $signed(a) >>> imm[4:0];
                kind_addi_w:  val = a + simm;
                kind_lu12i_w: val = {imm[19:0], 12'h0};
                kind_ld_w:    val = model_mem[addr[11:2]];
                kind_st_w: begin
                    model_mem[addr[11:2]] = d;
                    wr = 1'b0;
                end
                kind_jirl: begin
                    val = pc + 32'd4;
                    next_pc = a + (imm << 2);
                end
                kind_bl: begin
                    val = pc + 32'd4;
                    dst = 5'd1;
                    next_pc = pc + (imm << 2);
                end
                kind_b: begin
                    wr = 1'b0;
                    next_pc = pc + (imm << 2);
                end
                kind_beq: begin
                    wr = 1'b0;
                    if (a == d) next_pc = pc + (imm << 2);
                end
                kind_bne: begin
                    wr = 1'b0;
                    if (a != d) next_pc = pc + (imm << 2);
                end
                default: wr = 1'b0;
            endcase
            if (k inside {kind_b, kind_beq, kind_bne}) begin
                cycles = cycles + 2;
            end else if (k == kind_ld_w) begin
                cycles = cycles + 5;
            end else begin
                cycles = cycles + 4;
            end
            if (wr) begin
                ev.we = 1'b1;
                ev.pc = pc;
                ev.wnum = dst;
                ev.wdata = val;
                exp_q.push_back(ev);
                if (dst != 5'd0) model_regs[dst] = val;
            end
            pc = next_pc;
        end
        // a few spare cycles cover the reset release and the closing self-loop.
        budget_cycles = budget_cycles + cycles + 8;
        timeout_limit = (budget_cycles * 3) / 2;
    endtask

    task automatic check_trace(input wb_trace_t got, input wb_trace_t exp);
        checks = checks + 1;
        if (got.pc !== exp.pc) begin
            $display("error trace.pc: got %h expected %h", got.pc, exp.pc);
            errors = errors + 1;
        end
        if (got.wnum !== exp.wnum) begin
            $display("error trace.wnum: got %h expected %h", got.wnum, exp.wnum);
            errors = errors + 1;
        end
        if (got.wdata !== exp.wdata) begin
            $display("error trace.wdata: got %h expected %h", got.wdata, exp.wdata);
            errors = errors + 1;
        end
    endtask

    task automatic check_word(input string name, input logic [`CPU_XLEN-1:0] got,
                              input logic [`CPU_XLEN-1:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic load_and_reset();
        @(posedge clk);
        #2 reset = 1'b1;
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            if (c == 0) begin
                for (int i = 0; i < prog_len; i++) begin
                    mem.write_inst(`CPU_RESET_PC + 32'(i * 4), prog_word[i]);
                end
            end else if (trace.we || data_req.we) begin
                $display("a write enable was high while reset was held");
                errors = errors + 1;
            end
        end
        @(posedge clk);
        #2 reset = 1'b0;
        @(negedge clk);
        check_word("inst_addr", inst_addr, `CPU_RESET_PC);
        if (trace.we || data_req.we) begin
            $display("a write enable was high in the first fetch after reset");
            errors = errors + 1;
        end
    endtask

    task automatic run_program();
        wb_trace_t exp;
        run_model();
        load_and_reset();
        while (exp_q.size() > 0) begin
            @(negedge clk);
            if (trace.we) begin
                exp = exp_q.pop_front();
                check_trace(trace, exp);
            end
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run = tests_run + 1;
        if (errors == errors_before) begin
            $display("%s: pass", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("%s: fail with %0d mismatches", name, errors - errors_before);
        end
        prog_len = 0;
    endtask

    task automatic register_alu_test();
        int e0;
        e0 = errors;
        emit(kind_lu12i_w, 1, 0, 0, 32'h12345);
        emit(kind_addi_w, 1, 1, 0, 32'h678);
        emit(kind_lu12i_w, 2, 0, 0, 32'hfedcb);
        emit(kind_addi_w, 2, 2, 0, -291);
        emit(kind_add_w, 3, 1, 2, 0);
        emit(kind_sub_w, 4, 1, 2, 0);
        emit(kind_slt, 5, 1, 2, 0);
        emit(kind_sltu, 6, 1, 2, 0);
        emit(kind_nor, 7, 1, 2, 0);
        emit(kind_and, 8, 1, 2, 0);
        emit(kind_or, 9, 1, 2, 0);
        emit(kind_xor, 10, 1, 2, 0);
        emit(kind_slt, 11, 2, 1, 0);
        emit(kind_b, 0, 0, 0, 0);
        run_program();
        finish_test("register alu", e0);
    endtask

    task automatic immediate_shift_test();
        int e0;
        e0 = errors;
        emit(kind_addi_w, 1, 0, 0, -5);
        emit(kind_lu12i_w, 2, 0, 0, 32'h80000);
        emit(kind_addi_w, 2, 2, 0, -1);
        emit(kind_srai_w, 3, 2, 0, 4);
        emit(kind_srli_w, 4, 2, 0, 4);
        emit(kind_slli_w, 5, 1, 0, 3);
        emit(kind_srai_w, 6, 1, 0, 1);
        emit(kind_srli_w, 7, 1, 0, 31);
        emit(kind_addi_w, 0, 1, 0, 7);
        emit(kind_add_w, 8, 0, 1, 0);
        emit(kind_or, 9, 0, 0, 0);
        emit(kind_b, 0, 0, 0, 0);
        run_program();
        finish_test("immediates and shifts", e0);
    endtask

    task automatic memory_test();
        int e0;
        e0 = errors;
        emit(kind_addi_w, 1, 0, 0, 32'h100);
        emit(kind_lu12i_w, 2, 0, 0, 32'habcde);
        emit(kind_addi_w, 2, 2, 0, 32'h123);
        emit(kind_st_w, 2, 1, 0, 0);
        emit(kind_addi_w, 3, 0, 0, -77);
        emit(kind_st_w, 3, 1, 0, 8);
        emit(kind_st_w, 1, 1, 0, 32'h7fc);
        emit(kind_ld_w, 4, 1, 0, 0);
        emit(kind_ld_w, 5, 1, 0, 8);
        emit(kind_ld_w, 6, 1, 0, 32'h7fc);
        emit(kind_ld_w, 7, 0, 0, 32'h40);
        emit(kind_b, 0, 0, 0, 0);
        run_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_word($sformatf("dmem[%0d]", i), mem.read_word(32'(i) << 2), model_mem[i]);
        end
        finish_test("memory", e0);
    endtask

    task automatic control_flow_test();
        int e0;
        e0 = errors;
        emit(kind_addi_w, 1, 0, 0, 5);
        emit(kind_addi_w, 2, 0, 0, 5);
        emit(kind_beq, 2, 1, 0, 2);
        emit(kind_addi_w, 3, 0, 0, 1);
        emit(kind_bne, 2, 1, 0, 2);
        emit(kind_addi_w, 4, 0, 0, 2);
        emit(kind_addi_w, 2, 0, 0, 6);
        emit(kind_beq, 2, 1, 0, 2);
        emit(kind_addi_w, 5, 0, 0, 3);
        emit(kind_bne, 2, 1, 0, 2);
        emit(kind_addi_w, 6, 0, 0, 4);
        emit(kind_b, 0, 0, 0, 2);
        emit(kind_addi_w, 7, 0, 0, 5);
        emit(kind_bl, 0, 0, 0, 3);
        emit(kind_addi_w, 8, 0, 0, 9);
        emit(kind_b, 0, 0, 0, 0);
        emit(kind_addi_w, 9, 0, 0, 10);
        // returns through the link register to the instruction after bl.
        emit(kind_jirl, 10, 1, 0, 0);
        run_program();
        finish_test("control flow", e0);
    endtask

    task automatic random_alu_test();
        int         e0;
        int         pick;
        inst_kind_e k;
        e0 = errors;
        for (int r = 1; r < 8; r++) begin
            emit(kind_lu12i_w, r, 0, 0, int'(next_random() >> 12));
            emit(kind_addi_w, r, r, 0, int'(next_random() >> 20));
        end
        for (int n = 0; n < 40; n++) begin
            pick = int'(next_random() % 32'd13);
            case (pick)
                0:       k = kind_add_w;
                1:       k = kind_sub_w;
                2:       k = kind_slt;
                3:       k = kind_sltu;
                4:       k = kind_nor;
                5:       k = kind_and;
                6:       k = kind_or;
                7:       k = kind_xor;
                8:       k = kind_slli_w;
                9:       k = kind_srli_w;
                10:      k = kind_srai_w;
                11:      k = kind_addi_w;
                default: k = kind_lu12i_w;
            endcase
            emit(k, int'(next_random() % 32'd8), int'(next_random() % 32'd8),
                 int'(next_random() % 32'd8), int'(next_random() >> 12));
        end
        emit(kind_b, 0, 0, 0, 0);
        run_program();
        finish_test("random alu", e0);
    endtask

    task automatic reset_state_test();
        int e0;
        e0 = errors;
        emit(kind_lu12i_w, 1, 0, 0, 32'h00001);
        emit(kind_b, 0, 0, 0, 0);
        run_program();
        finish_test("reset state", e0);
    endtask

    initial begin
        reset = 1'b1;
        lcg_state = LCG_SEED;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        budget_cycles = 0;
        timeout_limit = 0;
        run_cycles = 0;
        prog_len = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = mem.fill_word(32'(i) << 2);
        end
        reset_state_test();
        register_alu_test();
        immediate_shift_test();
        memory_test();
        control_flow_test();
        random_alu_test();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
